// ==== logic/core_pkg.sv ====
package core_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int OPCODE_W   = 6;

    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f
    } opcode_e;

    typedef enum logic [OPCODE_W-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_kind_e;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [WORD_W-1:0]     pc;
        logic [WORD_W-1:0]     pc_4;
        logic [REG_ADDR_W-1:0] rs;
        logic [WORD_W-1:0]     data_a;
        logic [REG_ADDR_W-1:0] rt;
        logic [WORD_W-1:0]     data_b;
        logic [REG_ADDR_W-1:0] rd;     // destination, rd or rt
        logic                  reg_we;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [WORD_W-1:0]     imm32;
        logic [SHAMT_W-1:0]    shamt;
        branch_kind_e          branch_kind;
        logic [IMM_W-1:0]      branch_offset;
    } id_ex_t;

    typedef struct packed {
        logic [WORD_W-1:0]     pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [WORD_W-1:0]     value;
    } ex_result_t;

    typedef struct packed {
        logic       valid;
        ex_result_t res;
    } ex_wb_t;

endpackage

// ==== logic/pipe_stage_reg.sv ====
`timescale 1ns/10ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;    // squash into a bubble
        end else if (en) begin
            q <= d;
        end
    end

    // a flush must land on an edge where the whole pipe advances
    a_clear_needs_en: assert property (
        @(posedge clk) disable iff (!rst_n)
        clear |-> en
    );

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
    input  core_pkg::fetch_pkt_t            fetch,
    output logic [core_pkg::REG_ADDR_W-1:0] rs_addr,
    output logic [core_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [core_pkg::WORD_W-1:0]     rs_data,
    input  logic [core_pkg::WORD_W-1:0]     rt_data,
    output core_pkg::id_ex_t                id
);
    import core_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    logic [OPCODE_W-1:0] funct;
    logic [IMM_W-1:0]    imm16;
    logic                legal;

    assign opcode  = fetch.instr[31:26];
    assign rs_addr = fetch.instr[25:21];
    assign rt_addr = fetch.instr[20:16];
    assign funct   = fetch.instr[5:0];
    assign imm16   = fetch.instr[15:0];

    always_comb begin
        id               = '0;
        legal            = 1'b0;
        id.pc            = fetch.pc;
        id.pc_4          = fetch.pc + 32'd4;
        id.rs            = rs_addr;
        id.data_a        = rs_data;
        id.rt            = rt_addr;
        id.data_b        = rt_data;
        id.shamt         = fetch.instr[10:6];
        id.branch_offset = imm16;
        id.imm32         = {{(WORD_W-IMM_W){1'b0}}, imm16};   // zero-extended by default

        case (opcode)
            OP_RTYPE: begin
                id.rd     = fetch.instr[15:11];
                id.reg_we = 1'b1;
                legal     = 1'b1;
                case (funct)
                    FN_ADDU: id.alu_op = ALU_ADD;
                    FN_SUBU: id.alu_op = ALU_SUB;
                    FN_AND:  id.alu_op = ALU_AND;
                    FN_OR:   id.alu_op = ALU_OR;
                    FN_XOR:  id.alu_op = ALU_XOR;
                    FN_SLT:  id.alu_op = ALU_SLT;
                    FN_SLL:  id.alu_op = ALU_SLL;
                    FN_SRL:  id.alu_op = ALU_SRL;
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                legal      = 1'b1;
                id.rd      = rt_addr;
                id.reg_we  = 1'b1;
                id.use_imm = 1'b1;
                id.alu_op  = ALU_ADD;
                id.imm32   = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
            end
            OP_ANDI: begin
                legal      = 1'b1;
                id.rd      = rt_addr;
                id.reg_we  = 1'b1;
                id.use_imm = 1'b1;
                id.alu_op  = ALU_AND;
            end
            OP_ORI: begin
                legal      = 1'b1;
                id.rd      = rt_addr;
                id.reg_we  = 1'b1;
                id.use_imm = 1'b1;
                id.alu_op  = ALU_OR;
            end
            OP_LUI: begin
                legal      = 1'b1;
                id.rd      = rt_addr;
                id.reg_we  = 1'b1;
                id.use_imm = 1'b1;
                id.alu_op  = ALU_LUI;   // shifted up in the ALU
            end
            OP_BEQ: begin
                legal          = 1'b1;
                id.branch_kind = BR_EQ;
            end
            OP_BNE: begin
                legal          = 1'b1;
                id.branch_kind = BR_NE;
            end
            default: legal = 1'b0;
        endcase

        id.valid = fetch.valid && legal;    // unknown opcode becomes a bubble
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rt_addr,
    output logic [core_pkg::WORD_W-1:0]     rs_data,
    output logic [core_pkg::WORD_W-1:0]     rt_data,
    input  core_pkg::ex_wb_t                wr,
    input  logic                            wr_fire
);
    import core_pkg::*;

    logic [WORD_W-1:0] regs [1:31];    // r0 has no storage
    logic              we;

    assign we = wr_fire && wr.valid && (wr.res.rd != '0);

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wr.res.rd] <= wr.res.value;
        end
    end

    function automatic logic [WORD_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [WORD_W-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (we && (addr == wr.res.rd)) begin
            data = wr.res.value;    // write-through
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    a_wdata_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(wr.res.value)
    );

endmodule

// ==== logic/alu_stage.sv ====
`timescale 1ns/10ps

module alu_stage (
    input  core_pkg::id_ex_t            id,
    input  core_pkg::ex_wb_t            fwd,
    output core_pkg::ex_wb_t            res,
    output logic                        branch_taken,
    output logic [core_pkg::WORD_W-1:0] redirect_pc
);
    import core_pkg::*;

    logic [WORD_W-1:0] rs_val;
    logic [WORD_W-1:0] rt_val;
    logic [WORD_W-1:0] op_b;
    logic [WORD_W-1:0] value;
    logic              slt_bit;
    logic              ops_equal;

    // take the EX/WB value when it targets the same non-zero register
    function automatic logic [WORD_W-1:0] fwd_pick(
        input logic [REG_ADDR_W-1:0] idx,
        input logic [WORD_W-1:0]     reg_val,
        input ex_wb_t                src
    );
        logic [WORD_W-1:0] picked;
        picked = reg_val;
        if (src.valid && (src.res.rd != '0) && (src.res.rd == idx)) begin
            picked = src.res.value;
        end
        return picked;
    endfunction

    always_comb begin
        rs_val = fwd_pick(id.rs, id.data_a, fwd);
        rt_val = fwd_pick(id.rt, id.data_b, fwd);
    end

    assign op_b      = id.use_imm ? id.imm32 : rt_val;
    assign slt_bit   = $signed(rs_val) < $signed(op_b);
    assign ops_equal = (rs_val == rt_val);

    always_comb begin
        case (id.alu_op)
            ALU_ADD: value = rs_val + op_b;
            ALU_SUB: value = rs_val - op_b;
            ALU_AND: value = rs_val & op_b;
            ALU_OR:  value = rs_val | op_b;
            ALU_XOR: value = rs_val ^ op_b;
            ALU_SLT: value = {{(WORD_W-1){1'b0}}, slt_bit};
            ALU_SLL: value = op_b << id.shamt;    // shifts act on rt
            ALU_SRL: value = op_b >> id.shamt;
            ALU_LUI: value = {op_b[IMM_W-1:0], {IMM_W{1'b0}}};
            default: value = '0;
        endcase
    end

    always_comb begin
        res.valid     = id.valid && id.reg_we;
        res.res.pc    = id.pc;
        res.res.rd    = id.rd;
        res.res.value = value;
    end

    always_comb begin
        case (id.branch_kind)
            BR_EQ:   branch_taken = id.valid && ops_equal;
            BR_NE:   branch_taken = id.valid && !ops_equal;
            default: branch_taken = 1'b0;
        endcase
    end

    // word offset relative to the delay-slot address
    assign redirect_pc = id.pc_4 +
                         {{(WORD_W-IMM_W-2){id.branch_offset[IMM_W-1]}}, id.branch_offset, 2'b00};

endmodule

// ==== logic/hazard_ctrl.sv ====
`timescale 1ns/10ps

module hazard_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic exwb_valid,
    input  logic out_ready,
    input  logic branch_taken,
    output logic stage_en,
    output logic flush,
    output logic in_ready,
    output logic redirect_valid
);

    // one enable for every stage keeps forwarding distances fixed
    assign stage_en = !(exwb_valid && !out_ready);

    assign flush          = branch_taken && stage_en;
    assign redirect_valid = flush;
    assign in_ready       = stage_en && !branch_taken;  // fetch word is stale on a redirect

    // the flushed ID/EX slot cannot hold a second branch
    a_redirect_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid
    );

endmodule

// ==== logic/exec_slice_top.sv ====
`timescale 1ns/10ps

module exec_slice_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  core_pkg::fetch_pkt_t        in_pkt,
    output logic                        in_ready,
    output logic                        out_valid,
    input  logic                        out_ready,
    output core_pkg::ex_result_t        out_res,
    output logic                        redirect_valid,
    output logic [core_pkg::WORD_W-1:0] redirect_pc
);
    import core_pkg::*;

    fetch_pkt_t            in_merged;
    fetch_pkt_t            ifid_q;
    id_ex_t                id_d;
    id_ex_t                idex_q;
    ex_wb_t                ex_d;
    ex_wb_t                exwb_q;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [WORD_W-1:0]     rs_data;
    logic [WORD_W-1:0]     rt_data;
    logic                  stage_en;
    logic                  flush;
    logic                  branch_taken;
    logic                  wr_fire;

    always_comb begin
        in_merged       = in_pkt;
        in_merged.valid = in_valid;
    end

    assign out_valid = exwb_q.valid;
    assign out_res   = exwb_q.res;
    assign wr_fire   = out_valid && out_ready;

    pipe_stage_reg #(.payload_t(fetch_pkt_t)) u_if_id (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (stage_en),
        .clear (flush),
        .d     (in_merged),
        .q     (ifid_q)
    );

    instr_decoder u_decoder (
        .fetch   (ifid_q),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .id      (id_d)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr      (exwb_q),
        .wr_fire (wr_fire)
    );

    pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (stage_en),
        .clear (flush),
        .d     (id_d),
        .q     (idex_q)
    );

    alu_stage u_alu_stage (
        .id           (idex_q),
        .fwd          (exwb_q),
        .res          (ex_d),
        .branch_taken (branch_taken),
        .redirect_pc  (redirect_pc)
    );

    pipe_stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (stage_en),
        .clear (1'b0),      // branch leaves no result, nothing to squash here
        .d     (ex_d),
        .q     (exwb_q)
    );

    hazard_ctrl u_hazard_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .exwb_valid     (exwb_q.valid),
        .out_ready      (out_ready),
        .branch_taken   (branch_taken),
        .stage_en       (stage_en),
        .flush          (flush),
        .in_ready       (in_ready),
        .redirect_valid (redirect_valid)
    );

endmodule

// ==== bench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// 32-bit LCG, low bits have short periods so callers use the top bits
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

task automatic check_result(input string test, input ex_result_t exp, input ex_result_t act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected pc=%h rd=%0d value=%h actual pc=%h rd=%0d value=%h",
                 test, exp.pc, exp.rd, exp.value, act.pc, act.rd, act.value);
    end
endtask

task automatic check_redirect(input string test, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected redirect=%h actual redirect=%h", test, exp, act);
    end
endtask

task automatic compare_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %b actual %b", test, exp, act);
    end
endtask

`endif

// ==== bench/tb_exec_slice.sv ====
`timescale 1ns/10ps

module tb_exec_slice;
    import core_pkg::*;

    localparam int MAX_CYCLES = 2000;   // per program

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    fetch_pkt_t        in_pkt;
    logic              in_ready;
    logic              out_valid;
    logic              out_ready;
    ex_result_t        out_res;
    logic              redirect_valid;
    logic [WORD_W-1:0] redirect_pc;

    logic [WORD_W-1:0] imem [0:63];
    logic [WORD_W-1:0] model_regs [0:31];
    int                prog_len;
    int                errors;
    int                timeouts;
    logic [31:0]       lcg_state;
    ex_result_t        exp_q [$];
    logic [WORD_W-1:0] redir_q [$];

    `include "tb_checks.svh"

    exec_slice_top DUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_pkt(in_pkt), .in_ready(in_ready),
        .out_valid(out_valid), .out_ready(out_ready), .out_res(out_res),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [5:0] funct, input int rd, rs, rt, sh);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input int rt, rs,
                                           input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic emit(input logic [31:0] instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    // in-order ISA model, fills the expected result and redirect queues
    task automatic model_program();
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] val;
        logic [4:0]  dest;
        logic        wr;
        logic        taken;
        pc = '0;
        for (int step = 0; step < 256 && pc < prog_len * 4; step++) begin
            ins   = imem[pc[7:2]];
            a     = model_regs[ins[25:21]];
            b     = model_regs[ins[20:16]];
            sext  = {{16{ins[15]}}, ins[15:0]};
            dest  = ins[20:16];
            val   = '0;
            wr    = 1'b1;
            taken = 1'b0;
            case (ins[31:26])
                6'h00: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        6'h21: val = a + b;
                        6'h23: val = a - b;
                        6'h24: val = a & b;
                        6'h25: val = a | b;
                        6'h26: val = a ^ b;
                        6'h2a: val = {31'd0, $signed(a) < $signed(b)};
                        6'h00: val = b << ins[10:6];
                        6'h02: val = b >> ins[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: val = a + sext;
                6'h0c: val = a & {16'd0, ins[15:0]};
                6'h0d: val = a | {16'd0, ins[15:0]};
                6'h0f: val = {ins[15:0], 16'd0};
                6'h04: {wr, taken} = {1'b0, a == b};
                6'h05: {wr, taken} = {1'b0, a != b};
                default: wr = 1'b0;                     // bubble
            endcase
            if (wr) begin
                exp_q.push_back({pc, dest, val});
                if (dest != 5'd0) begin
                    model_regs[dest] = val;
                end
            end
            if (taken) begin
                pc = pc + 32'd4 + {sext[29:0], 2'b00};
                redir_q.push_back(pc);
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    // acts as the fetch stage and the result sink until the pipe drains
    task automatic run_program(input string test, input bit rand_ready);
        logic [WORD_W-1:0] fetch_pc;
        logic [31:0]       rnd;
        ex_result_t        held;
        logic              holding;
        int                quiet;
        int                cycles;
        fetch_pc = '0;
        holding  = 1'b0;
        quiet    = 0;
        cycles   = 0;
        model_program();
        while (quiet < 4 && cycles < MAX_CYCLES) begin
            @(negedge clk);
            rnd       = lcg_next();
            in_valid  = (fetch_pc < prog_len * 4);
            in_pkt    = {1'b1, fetch_pc, in_valid ? imem[fetch_pc[7:2]] : 32'd0};
            out_ready = rand_ready ? rnd[31] : 1'b1;
            @(posedge clk);
            cycles++;
            if (holding && out_valid) begin
                check_result({test, " hold"}, held, out_res);   // stalled output must not move
            end
            holding = out_valid && !out_ready;
            held    = out_res;
            if (out_valid && out_ready && exp_q.size() == 0) begin
                errors++;
                $display("%s: unexpected result from pc %h", test, out_res.pc);
            end else if (out_valid && out_ready) begin
                check_result(test, exp_q.pop_front(), out_res);
            end
            if (redirect_valid && redir_q.size() == 0) begin
                errors++;
                $display("%s: unexpected redirect to %h", test, redirect_pc);
            end else if (redirect_valid) begin
                check_redirect(test, redir_q.pop_front(), redirect_pc);
            end
            if (redirect_valid) begin
                fetch_pc = redirect_pc;
            end else if (in_valid && in_ready) begin
                fetch_pc = fetch_pc + 32'd4;
            end
            quiet = (in_valid || out_valid || redirect_valid) ? 0 : quiet + 1;
        end
        if (quiet < 4) begin
            timeouts++;
            $display("%s: pipeline did not drain within %0d cycles", test, MAX_CYCLES);
        end
        if (exp_q.size() != 0 || redir_q.size() != 0) begin
            errors++;
            $display("%s: %0d results and %0d redirects never arrived",
                     test, exp_q.size(), redir_q.size());
            exp_q.delete();
            redir_q.delete();
        end
    endtask

    task automatic test_reset();
        compare_flag("reset out_valid", 1'b0, out_valid);
        compare_flag("reset redirect_valid", 1'b0, redirect_valid);
        compare_flag("reset in_ready", 1'b1, in_ready);
        prog_len = 0;
        for (int r = 1; r < 32; r++) begin
            emit(i_type(OP_ORI, r, 0, 16'h0000));
        end
        run_program("clear regs", 1'b0);
    endtask

    task automatic test_arith();
        prog_len = 0;
        emit(i_type(OP_ORI, 1, 0, 16'h1234));
        emit(i_type(OP_LUI, 2, 0, 16'h8000));
        emit(i_type(OP_ADDIU, 3, 0, 16'hfffb));     // -5
        emit(r_type(FN_ADDU, 4, 1, 3, 0));
        emit(r_type(FN_SUBU, 5, 3, 1, 0));
        emit(r_type(FN_AND, 6, 1, 3, 0));
        emit(r_type(FN_OR, 7, 2, 1, 0));
        emit(r_type(FN_XOR, 8, 7, 3, 0));
        emit(r_type(FN_SLT, 9, 3, 1, 0));           // negative below positive
        emit(r_type(FN_SLT, 10, 1, 3, 0));
        emit(r_type(FN_SLT, 11, 2, 3, 0));
        emit(r_type(FN_SLL, 12, 0, 1, 4));
        emit(r_type(FN_SRL, 13, 0, 2, 31));
        emit(i_type(OP_ANDI, 14, 3, 16'hff00));
        emit(i_type(OP_ADDIU, 15, 1, 16'h8001));
        emit(32'hfc00_0000);                        // unknown opcode
        run_program("arith", 1'b0);
    endtask

    task automatic test_forwarding();
        prog_len = 0;
        emit(i_type(OP_ADDIU, 1, 0, 16'h0007));
        emit(i_type(OP_ADDIU, 2, 1, 16'h0003));     // distance one
        emit(r_type(FN_ADDU, 3, 2, 1, 0));          // one and two
        emit(r_type(FN_SUBU, 4, 3, 2, 0));
        emit(r_type(FN_XOR, 1, 4, 3, 0));
        emit(r_type(FN_SLL, 5, 0, 1, 2));
        emit(r_type(FN_OR, 6, 5, 1, 0));
        emit(r_type(FN_ADDU, 7, 6, 6, 0));
        run_program("forwarding", 1'b0);
    endtask

    task automatic test_branches();
        prog_len = 0;
        emit(i_type(OP_ADDIU, 1, 0, 16'd5));
        emit(i_type(OP_ADDIU, 2, 0, 16'd5));
        emit(i_type(OP_BEQ, 2, 1, 16'd2));          // taken
        emit(i_type(OP_ADDIU, 3, 0, 16'd1));
        emit(i_type(OP_ADDIU, 4, 0, 16'd2));
        emit(i_type(OP_BNE, 2, 1, 16'd5));          // not taken
        emit(i_type(OP_ADDIU, 5, 0, 16'd3));
        emit(i_type(OP_BNE, 1, 5, 16'd1));
        emit(i_type(OP_ADDIU, 6, 0, 16'd9));
        emit(i_type(OP_BEQ, 1, 5, 16'd3));
        emit(i_type(OP_ADDIU, 7, 5, 16'd1));
        emit(i_type(OP_BEQ, 0, 0, 16'd1));
        emit(i_type(OP_ADDIU, 8, 0, 16'd4));
        emit(i_type(OP_ORI, 9, 7, 16'h0010));
        run_program("branches", 1'b0);
    endtask

    task automatic test_backpressure();
        logic [31:0] rnd;
        prog_len = 0;
        for (int i = 0; i < 24; i++) begin
            rnd = lcg_next();
            case (rnd[31:29])
                3'd0: emit(r_type(FN_ADDU, rnd[28:26], rnd[25:23], rnd[22:20], 0));
                3'd1: emit(r_type(FN_SUBU, rnd[28:26], rnd[25:23], rnd[22:20], 0));
                3'd2: emit(r_type(FN_SLT, rnd[28:26], rnd[25:23], rnd[22:20], 0));
                3'd3: emit(r_type(FN_SLL, rnd[28:26], 0, rnd[22:20], rnd[19:15]));
                3'd4: emit(i_type(OP_ADDIU, rnd[28:26], rnd[25:23], rnd[19:4]));
                3'd5: emit(i_type(OP_ORI, rnd[28:26], rnd[25:23], rnd[19:4]));
                3'd6: emit(i_type(OP_LUI, rnd[28:26], 0, rnd[19:4]));
                default: emit(i_type(OP_BNE, rnd[28:26], rnd[25:23], 16'd1));
            endcase
        end
        run_program("backpressure", 1'b1);
    endtask

    task automatic test_reg_zero();
        prog_len = 0;
        emit(i_type(OP_ADDIU, 0, 0, 16'h0055));
        emit(r_type(FN_ADDU, 1, 0, 0, 0));          // r0 is never forwarded
        emit(i_type(OP_ORI, 0, 1, 16'h0077));
        emit(r_type(FN_OR, 2, 0, 1, 0));
        emit(i_type(OP_ADDIU, 3, 0, 16'h0001));
        emit(r_type(FN_ADDU, 4, 0, 3, 0));
        run_program("reg zero", 1'b0);
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pkt    = '0;
        out_ready = 1'b0;
        errors    = 0;
        timeouts  = 0;
        prog_len  = 0;
        lcg_state = 32'hd3b29cd1;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_arith();
        test_forwarding();
        test_branches();
        test_backpressure();
        test_reg_zero();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+bench
logic/core_pkg.sv
logic/pipe_stage_reg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/alu_stage.sv
logic/hazard_ctrl.sv
logic/exec_slice_top.sv
bench/tb_exec_slice.sv
